// ==== flist.f ====
hdl/eth_dma_pkg.sv
hdl/eth_bd_arbiter.sv
hdl/eth_dma_tx.sv
hdl/eth_dma_rx.sv
hdl/eth_dma.sv
testbench/eth_dma_tb_models.sv
testbench/eth_dma_tb.sv

// ==== hdl/eth_bd_arbiter.sv ====
`default_nettype none

module eth_bd_arbiter (
   input  wire                  clk_i,
   input  wire                  arst_i,
   input  wire                  tx_req_i,
   input  wire                  rx_req_i,
   output logic                 tx_ack_o,
   output logic                 rx_ack_o,
   input  wire eth_dma_pkg::bd_cmd_t tx_cmd_i,
   input  wire eth_dma_pkg::bd_cmd_t rx_cmd_i,
   output eth_dma_pkg::bd_cmd_t bd_cmd_o
);

   typedef enum logic [1:0] {
      st_idle,
      st_grant_tx,
      st_grant_rx,
      st_release
   } state_t;

   state_t state_q;
   state_t state_d;

   // Transmit wins when both ask in the same cycle
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle:
            if (tx_req_i)
               state_d = st_grant_tx;
            else if (rx_req_i)
               state_d = st_grant_rx;
         st_grant_tx:
            if (!tx_req_i)
               state_d = st_release;
         st_grant_rx:
            if (!rx_req_i)
               state_d = st_release;
         default:
            state_d = st_idle;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i)
         state_q <= st_idle;
      else
         state_q <= state_d;
   end

   assign tx_ack_o = (state_q == st_grant_tx);
   assign rx_ack_o = (state_q == st_grant_rx);

   // Only the owner reaches the memory
   always_comb begin
      bd_cmd_o = '0;
      if (tx_ack_o)
         bd_cmd_o = tx_cmd_i;
      else if (rx_ack_o)
         bd_cmd_o = rx_cmd_i;
   end

   a_ack_onehot: assert property (@(posedge clk_i) disable iff (arst_i)
      !(tx_ack_o && rx_ack_o));

endmodule

`default_nettype wire

// ==== hdl/eth_dma.sv ====
`default_nettype none

module eth_dma #(
   parameter int MAX_BURST = 16
) (
   input  wire                     clk_i,
   input  wire                     arst_i,
   input  wire                     tx_en_i,
   input  wire                     rx_en_i,
   input  wire eth_dma_pkg::bd_addr_t tx_bd_num_i,

   // Descriptor memory
   output eth_dma_pkg::bd_cmd_t    bd_cmd_o,
   input  wire eth_dma_pkg::word_t bd_rdata_i,

   // Frame buffers
   output eth_dma_pkg::fb_wr_t     tx_fb_wr_o,
   output eth_dma_pkg::fb_rd_t     rx_fb_rd_o,
   input  wire eth_dma_pkg::word_t rx_fb_rdata_i,

   // AXI4 read side
   output eth_dma_pkg::axi_ar_t    axi_ar_o,
   input  wire                     axi_arready_i,
   input  wire eth_dma_pkg::word_t axi_rdata_i,
   input  wire                     axi_rvalid_i,
   input  wire                     axi_rlast_i,
   output logic                    axi_rready_o,

   // AXI4 write side
   output eth_dma_pkg::axi_aw_t    axi_aw_o,
   input  wire                     axi_awready_i,
   output eth_dma_pkg::axi_w_t     axi_w_o,
   input  wire                     axi_wready_i,
   input  wire                     axi_bvalid_i,
   output logic                    axi_bready_o,

   output logic                    tx_irq_o,
   output logic                    rx_irq_o
);

   wire                       tx_req;
   wire                       rx_req;
   wire                       tx_ack;
   wire                       rx_ack;
   wire eth_dma_pkg::bd_cmd_t tx_cmd;
   wire eth_dma_pkg::bd_cmd_t rx_cmd;

   // Responses are never refused
   assign axi_bready_o = 1'b1;

   eth_bd_arbiter u_arbiter (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .tx_req_i (tx_req),
      .rx_req_i (rx_req),
      .tx_ack_o (tx_ack),
      .rx_ack_o (rx_ack),
      .tx_cmd_i (tx_cmd),
      .rx_cmd_i (rx_cmd),
      .bd_cmd_o (bd_cmd_o)
   );

   eth_dma_tx #(
      .MAX_BURST (MAX_BURST)
   ) u_tx (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .en_i          (tx_en_i),
      .tx_bd_num_i   (tx_bd_num_i),
      .bd_req_o      (tx_req),
      .bd_ack_i      (tx_ack),
      .bd_cmd_o      (tx_cmd),
      .bd_rdata_i    (bd_rdata_i),
      .fb_wr_o       (tx_fb_wr_o),
      .axi_ar_o      (axi_ar_o),
      .axi_arready_i (axi_arready_i),
      .axi_rdata_i   (axi_rdata_i),
      .axi_rvalid_i  (axi_rvalid_i),
      .axi_rlast_i   (axi_rlast_i),
      .axi_rready_o  (axi_rready_o),
      .irq_o         (tx_irq_o)
   );

   // Descriptor read data goes to both engines
   eth_dma_rx #(
      .MAX_BURST (MAX_BURST)
   ) u_rx (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .en_i          (rx_en_i),
      .tx_bd_num_i   (tx_bd_num_i),
      .bd_req_o      (rx_req),
      .bd_ack_i      (rx_ack),
      .bd_cmd_o      (rx_cmd),
      .bd_rdata_i    (bd_rdata_i),
      .fb_rd_o       (rx_fb_rd_o),
      .fb_rdata_i    (rx_fb_rdata_i),
      .axi_aw_o      (axi_aw_o),
      .axi_awready_i (axi_awready_i),
      .axi_w_o       (axi_w_o),
      .axi_wready_i  (axi_wready_i),
      .axi_bvalid_i  (axi_bvalid_i),
      .irq_o         (rx_irq_o)
   );

endmodule

`default_nettype wire

// ==== hdl/eth_dma_pkg.sv ====
`default_nettype none

package eth_dma_pkg;

   localparam int BD_ADDR_W  = 8;
   localparam int FB_ADDR_W  = 9;
   localparam int AXI_ADDR_W = 32;

   // Descriptor word 0 fields
   localparam int BD_LEN_LSB   = 16;
   localparam int BD_READY_BIT = 15;
   localparam int BD_WRAP_BIT  = 13;

   typedef logic [31:0]           word_t;
   typedef logic [BD_ADDR_W-1:0]  bd_addr_t;
   typedef logic [FB_ADDR_W-1:0]  fb_addr_t;
   typedef logic [15:0]           frame_len_t;
   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [7:0]            axi_len_t;

   // Descriptor memory access
   typedef struct packed {
      logic     en;
      logic     we;
      bd_addr_t addr;
      word_t    wdata;
   } bd_cmd_t;

   // Transmit frame buffer write port
   typedef struct packed {
      logic     we;
      fb_addr_t addr;
      word_t    data;
   } fb_wr_t;

   // Receive frame buffer read request
   typedef struct packed {
      logic     en;
      fb_addr_t addr;
   } fb_rd_t;

   // AXI address channel, len is beats minus one
   typedef struct packed {
      logic      valid;
      axi_addr_t addr;
      axi_len_t  len;
   } axi_ar_t;

   typedef axi_ar_t axi_aw_t;

   typedef struct packed {
      logic  valid;
      word_t data;
      logic  last;
   } axi_w_t;

endpackage

`default_nettype wire

// ==== hdl/eth_dma_rx.sv ====
`default_nettype none

module eth_dma_rx #(
   parameter int MAX_BURST = 16
) (
   input  wire                   clk_i,
   input  wire                   arst_i,
   input  wire                   en_i,
   input  wire eth_dma_pkg::bd_addr_t tx_bd_num_i,
   output logic                  bd_req_o,
   input  wire                   bd_ack_i,
   output eth_dma_pkg::bd_cmd_t  bd_cmd_o,
   input  wire eth_dma_pkg::word_t bd_rdata_i,
   output eth_dma_pkg::fb_rd_t   fb_rd_o,
   input  wire eth_dma_pkg::word_t fb_rdata_i,
   output eth_dma_pkg::axi_aw_t  axi_aw_o,
   input  wire                   axi_awready_i,
   output eth_dma_pkg::axi_w_t   axi_w_o,
   input  wire                   axi_wready_i,
   input  wire                   axi_bvalid_i,
   output logic                  irq_o
);

   typedef enum logic [4:0] {
      st_idle, st_req, st_rd0, st_chk, st_rd1, st_rel, st_addr, st_fetch,
      st_load, st_beat, st_resp, st_next, st_sreq, st_stat, st_srel, st_irq,
      st_poll, st_gap
   } state_t;

   state_t                  state_q;
   state_t                  state_d;
   eth_dma_pkg::bd_addr_t   bd_idx_q;
   eth_dma_pkg::bd_addr_t   bd_base;
   eth_dma_pkg::word_t      bd_word0_q;
   eth_dma_pkg::axi_addr_t  ptr_q;
   eth_dma_pkg::word_t      hold_q;
   eth_dma_pkg::frame_len_t cnt_q;
   eth_dma_pkg::frame_len_t frame_len;
   eth_dma_pkg::frame_len_t remain;
   eth_dma_pkg::axi_len_t   burst_m1;
   eth_dma_pkg::axi_len_t   blen_q;
   eth_dma_pkg::axi_len_t   beat_q;
   logic                    w_xfer;
   logic                    w_last;

   assign bd_base   = {bd_idx_q[eth_dma_pkg::BD_ADDR_W-2:0], 1'b0};
   assign frame_len = bd_word0_q[eth_dma_pkg::BD_LEN_LSB +: $bits(eth_dma_pkg::frame_len_t)];
   assign remain    = frame_len - cnt_q;
   assign w_xfer    = axi_w_o.valid && axi_wready_i;
   assign w_last    = (beat_q == blen_q);

   assign burst_m1 = (remain > eth_dma_pkg::frame_len_t'(MAX_BURST)) ?
                     eth_dma_pkg::axi_len_t'(MAX_BURST - 1) :
                     eth_dma_pkg::axi_len_t'(remain - 1'b1);

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle:  if (en_i) state_d = st_req;
         st_req:   if (bd_ack_i) state_d = st_rd0;
         st_rd0:   state_d = st_chk;
         st_chk:
            if (bd_rdata_i[eth_dma_pkg::BD_READY_BIT])
               state_d = st_rd1;
            else
               state_d = st_poll;
         st_rd1:   state_d = st_rel;
         st_rel:   if (!bd_ack_i) state_d = st_addr;
         st_addr:  if (axi_awready_i) state_d = st_fetch;
         // One word in flight from the frame buffer at a time
         st_fetch: state_d = st_load;
         st_load:  state_d = st_beat;
         st_beat:
            if (w_xfer)
               state_d = w_last ? st_resp : st_fetch;
         st_resp:  if (axi_bvalid_i) state_d = st_next;
         st_next:  state_d = (remain == '0) ? st_sreq : st_addr;
         st_sreq:  if (bd_ack_i) state_d = st_stat;
         st_stat:  state_d = st_srel;
         st_srel:  if (!bd_ack_i) state_d = st_irq;
         st_irq:   state_d = st_req;
         st_poll:  if (!bd_ack_i) state_d = st_gap;
         default:  state_d = st_req;
      endcase
      if (!en_i)
         state_d = st_idle;
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q  <= st_idle;
         bd_idx_q <= '0;
         cnt_q    <= '0;
         beat_q   <= '0;
         blen_q   <= '0;
      end else begin
         state_q <= state_d;
         // Receive ring starts right after the transmit ring
         if (!en_i || state_q == st_idle)
            bd_idx_q <= tx_bd_num_i;
         else if (state_q == st_irq)
            bd_idx_q <= bd_word0_q[eth_dma_pkg::BD_WRAP_BIT] ? tx_bd_num_i : bd_idx_q + 1'b1;
         if (state_q == st_rd1)
            cnt_q <= '0;
         else if (w_xfer)
            cnt_q <= cnt_q + 1'b1;
         if (state_q == st_addr && axi_awready_i) begin
            blen_q <= burst_m1;
            beat_q <= '0;
         end else if (w_xfer) begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == st_chk)
         bd_word0_q <= bd_rdata_i;
      if (state_q == st_rd1)
         ptr_q <= bd_rdata_i;
      if (state_q == st_load)
         hold_q <= fb_rdata_i;
   end

   always_comb begin
      bd_req_o = state_q inside {st_req, st_rd0, st_chk, st_rd1, st_sreq, st_stat};
      bd_cmd_o = '0;
      bd_cmd_o.addr = bd_base;
      case (state_q)
         st_rd0: bd_cmd_o.en = 1'b1;
         st_chk: begin
            bd_cmd_o.en   = bd_rdata_i[eth_dma_pkg::BD_READY_BIT];
            bd_cmd_o.addr = bd_base + 1'b1;
         end
         st_stat: begin
            bd_cmd_o.en    = 1'b1;
            bd_cmd_o.we    = 1'b1;
            bd_cmd_o.wdata = bd_word0_q;
            bd_cmd_o.wdata[eth_dma_pkg::BD_READY_BIT] = 1'b0;
         end
         default: ;
      endcase
   end

   always_comb begin
      fb_rd_o.en   = (state_q == st_fetch);
      fb_rd_o.addr = eth_dma_pkg::fb_addr_t'(cnt_q);
   end

   // Beat k goes to byte address ptr + 4k
   always_comb begin
      axi_aw_o.valid = (state_q == st_addr);
      axi_aw_o.addr  = ptr_q + eth_dma_pkg::axi_addr_t'({cnt_q, 2'b00});
      axi_aw_o.len   = burst_m1;
      axi_w_o.valid  = (state_q == st_beat);
      axi_w_o.data   = hold_q;
      axi_w_o.last   = (state_q == st_beat) && w_last;
   end

   assign irq_o = (state_q == st_irq);

   a_w_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      axi_w_o.valid && !axi_wready_i && en_i |=> axi_w_o.valid && $stable(axi_w_o));

   a_beat_bound: assert property (@(posedge clk_i) disable iff (arst_i)
      w_xfer |-> beat_q <= blen_q);

endmodule

`default_nettype wire

// ==== hdl/eth_dma_tx.sv ====
`default_nettype none

module eth_dma_tx #(
   parameter int MAX_BURST = 16
) (
   input  wire                   clk_i,
   input  wire                   arst_i,
   input  wire                   en_i,
   input  wire eth_dma_pkg::bd_addr_t tx_bd_num_i,
   output logic                  bd_req_o,
   input  wire                   bd_ack_i,
   output eth_dma_pkg::bd_cmd_t  bd_cmd_o,
   input  wire eth_dma_pkg::word_t bd_rdata_i,
   output eth_dma_pkg::fb_wr_t   fb_wr_o,
   output eth_dma_pkg::axi_ar_t  axi_ar_o,
   input  wire                   axi_arready_i,
   input  wire eth_dma_pkg::word_t axi_rdata_i,
   input  wire                   axi_rvalid_i,
   input  wire                   axi_rlast_i,
   output logic                  axi_rready_o,
   output logic                  irq_o
);

   typedef enum logic [3:0] {
      st_idle, st_req, st_rd0, st_chk, st_rd1, st_rel, st_addr, st_data,
      st_next, st_sreq, st_stat, st_srel, st_irq, st_poll, st_gap
   } state_t;

   state_t                  state_q;
   state_t                  state_d;
   eth_dma_pkg::bd_addr_t   bd_idx_q;
   eth_dma_pkg::bd_addr_t   bd_base;
   eth_dma_pkg::word_t      bd_word0_q;
   eth_dma_pkg::axi_addr_t  ptr_q;
   eth_dma_pkg::frame_len_t cnt_q;
   eth_dma_pkg::frame_len_t frame_len;
   eth_dma_pkg::frame_len_t remain;
   eth_dma_pkg::axi_len_t   burst_m1;
   logic                    r_xfer;
   logic                    ring_end;

   assign bd_base   = {bd_idx_q[eth_dma_pkg::BD_ADDR_W-2:0], 1'b0};
   assign frame_len = bd_word0_q[eth_dma_pkg::BD_LEN_LSB +: $bits(eth_dma_pkg::frame_len_t)];
   assign remain    = frame_len - cnt_q;
   assign r_xfer    = axi_rvalid_i && axi_rready_o;

   // Last transmit descriptor sits just below the receive ring
   assign ring_end  = (bd_idx_q + 1'b1 == tx_bd_num_i);

   // Burst is capped by MAX_BURST and the words still to move
   assign burst_m1 = (remain > eth_dma_pkg::frame_len_t'(MAX_BURST)) ?
                     eth_dma_pkg::axi_len_t'(MAX_BURST - 1) :
                     eth_dma_pkg::axi_len_t'(remain - 1'b1);

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: if (en_i) state_d = st_req;
         st_req:  if (bd_ack_i) state_d = st_rd0;
         st_rd0:  state_d = st_chk;
         st_chk:
            if (bd_rdata_i[eth_dma_pkg::BD_READY_BIT])
               state_d = st_rd1;
            else
               state_d = st_poll;
         st_rd1:  state_d = st_rel;
         st_rel:  if (!bd_ack_i) state_d = st_addr;
         st_addr: if (axi_arready_i) state_d = st_data;
         st_data: if (r_xfer && axi_rlast_i) state_d = st_next;
         st_next: state_d = (remain == '0) ? st_sreq : st_addr;
         st_sreq: if (bd_ack_i) state_d = st_stat;
         st_stat: state_d = st_srel;
         st_srel: if (!bd_ack_i) state_d = st_irq;
         st_irq:  state_d = st_req;
         // Extra idle cycle lets the receive engine win the port
         st_poll: if (!bd_ack_i) state_d = st_gap;
         default: state_d = st_req;
      endcase
      if (!en_i)
         state_d = st_idle;
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q  <= st_idle;
         bd_idx_q <= '0;
         cnt_q    <= '0;
      end else begin
         state_q <= state_d;
         if (!en_i || state_q == st_idle)
            bd_idx_q <= '0;
         else if (state_q == st_irq)
            bd_idx_q <= (bd_word0_q[eth_dma_pkg::BD_WRAP_BIT] || ring_end) ?
                        '0 : bd_idx_q + 1'b1;
         if (state_q == st_rd1)
            cnt_q <= '0;
         else if (r_xfer)
            cnt_q <= cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == st_chk)
         bd_word0_q <= bd_rdata_i;
      if (state_q == st_rd1)
         ptr_q <= bd_rdata_i;
   end

   // Descriptor port commands
   always_comb begin
      bd_req_o = state_q inside {st_req, st_rd0, st_chk, st_rd1, st_sreq, st_stat};
      bd_cmd_o = '0;
      bd_cmd_o.addr = bd_base;
      case (state_q)
         st_rd0: bd_cmd_o.en = 1'b1;
         st_chk: begin
            bd_cmd_o.en   = bd_rdata_i[eth_dma_pkg::BD_READY_BIT];
            bd_cmd_o.addr = bd_base + 1'b1;
         end
         st_stat: begin
            bd_cmd_o.en    = 1'b1;
            bd_cmd_o.we    = 1'b1;
            bd_cmd_o.wdata = bd_word0_q;
            bd_cmd_o.wdata[eth_dma_pkg::BD_READY_BIT] = 1'b0;
         end
         default: ;
      endcase
   end

   always_comb begin
      axi_ar_o.valid = (state_q == st_addr);
      axi_ar_o.addr  = ptr_q + eth_dma_pkg::axi_addr_t'({cnt_q, 2'b00});
      axi_ar_o.len   = burst_m1;
   end

   assign axi_rready_o = (state_q == st_data);
   assign irq_o        = (state_q == st_irq);

   // Word k of the frame lands at buffer address k
   always_comb begin
      fb_wr_o.we   = r_xfer;
      fb_wr_o.addr = eth_dma_pkg::fb_addr_t'(cnt_q);
      fb_wr_o.data = axi_rdata_i;
   end

   a_ar_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      axi_ar_o.valid && !axi_arready_i && en_i |=> axi_ar_o.valid && $stable(axi_ar_o));

   // Every buffer write stays inside the current frame
   a_fb_wr_in_frame: assert property (@(posedge clk_i) disable iff (arst_i)
      fb_wr_o.we |-> cnt_q < frame_len);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module eth_dma_tb \
   -f flist.f -o eth_dma_sim

./obj_dir/eth_dma_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
   exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
   exit 1
fi

// ==== testbench/eth_dma_tb.sv ====
`default_nettype none

module eth_dma_tb;

   logic                        clk_i = 1'b0;
   logic                        arst_i;
   logic                        tx_en;
   logic                        rx_en;
   eth_dma_pkg::bd_addr_t       tx_bd_num;
   eth_dma_pkg::bd_cmd_t        bd_cmd;
   eth_dma_pkg::word_t          bd_rdata;
   eth_dma_pkg::fb_wr_t         tx_fb_wr;
   eth_dma_pkg::fb_rd_t         rx_fb_rd;
   eth_dma_pkg::word_t          rx_fb_rdata;
   eth_dma_pkg::axi_ar_t        axi_ar;
   eth_dma_pkg::axi_aw_t        axi_aw;
   eth_dma_pkg::axi_w_t         axi_w;
   eth_dma_pkg::word_t          axi_rdata;
   logic                        arready, rvalid, rlast, rready;
   logic                        awready, wready, bvalid, bready;
   logic                        tx_irq, rx_irq;

   logic [3:0]                  ready_go;
   logic [3:0]                  stall_bits;
   logic                        stall_on;
   eth_dma_pkg::word_t          data_lfsr;
   eth_dma_pkg::word_t          stall_lfsr;
   eth_dma_pkg::word_t          exp_tx [0:15];
   eth_dma_pkg::word_t          exp_rx [0:15];
   int                          err_cnt;
   int                          tx_irq_cnt;
   int                          rx_irq_cnt;

   eth_dma #(.MAX_BURST(4)) dut0 (
      .clk_i(clk_i), .arst_i(arst_i), .tx_en_i(tx_en), .rx_en_i(rx_en),
      .tx_bd_num_i(tx_bd_num), .bd_cmd_o(bd_cmd), .bd_rdata_i(bd_rdata),
      .tx_fb_wr_o(tx_fb_wr), .rx_fb_rd_o(rx_fb_rd), .rx_fb_rdata_i(rx_fb_rdata),
      .axi_ar_o(axi_ar), .axi_arready_i(arready), .axi_rdata_i(axi_rdata),
      .axi_rvalid_i(rvalid), .axi_rlast_i(rlast), .axi_rready_o(rready),
      .axi_aw_o(axi_aw), .axi_awready_i(awready), .axi_w_o(axi_w),
      .axi_wready_i(wready), .axi_bvalid_i(bvalid), .axi_bready_o(bready),
      .tx_irq_o(tx_irq), .rx_irq_o(rx_irq)
   );

   eth_dma_tb_models models0 (
      .clk_i(clk_i), .arst_i(arst_i), .go_i(ready_go), .bd_cmd_i(bd_cmd),
      .bd_rdata_o(bd_rdata), .tx_fb_wr_i(tx_fb_wr), .rx_fb_rd_i(rx_fb_rd),
      .rx_fb_rdata_o(rx_fb_rdata), .axi_ar_i(axi_ar), .axi_arready_o(arready),
      .axi_rdata_o(axi_rdata), .axi_rvalid_o(rvalid), .axi_rlast_o(rlast),
      .axi_rready_i(rready), .axi_aw_i(axi_aw), .axi_awready_o(awready),
      .axi_w_i(axi_w), .axi_wready_o(wready), .axi_bvalid_o(bvalid)
   );

   always #2 clk_i = ~clk_i;

   function automatic eth_dma_pkg::word_t lfsr_next(input eth_dma_pkg::word_t s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Ready stalls and interrupt counters
   always @(posedge clk_i) begin
      for (int i = 0; i < 4; i++) begin
         stall_lfsr    = lfsr_next(stall_lfsr);
         stall_bits[i] = stall_lfsr[0];
      end
      ready_go <= stall_on ? stall_bits : 4'hf;
      if (tx_irq)
         tx_irq_cnt <= tx_irq_cnt + 1;
      if (rx_irq)
         rx_irq_cnt <= rx_irq_cnt + 1;
   end

   task automatic next_word(output eth_dma_pkg::word_t w);
      for (int i = 0; i < 32; i++) begin
         data_lfsr = lfsr_next(data_lfsr);
         w[i]      = data_lfsr[0];
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         err_cnt++;
         $display("Test failed");
         $fatal(1);
      end
   endtask

   function automatic eth_dma_pkg::word_t bd_word0(input int len, input logic wrap);
      eth_dma_pkg::word_t w;
      w = '0;
      w[eth_dma_pkg::BD_LEN_LSB +: 16] = 16'(len);
      w[eth_dma_pkg::BD_READY_BIT]     = 1'b1;
      w[eth_dma_pkg::BD_WRAP_BIT]      = wrap;
      return w;
   endfunction

   // Pointer first so the ready bit never exposes a stale address
   task automatic set_bd(input int idx, input int len, input logic wrap, input int ptr);
      models0.bd_mem[2*idx+1] = ptr;
      models0.bd_mem[2*idx]   = bd_word0(len, wrap);
   endtask

   task automatic fill_ext(input int ptr, input int len);
      eth_dma_pkg::word_t w;
      for (int i = 0; i < len; i++) begin
         next_word(w);
         exp_tx[i] = w ^ (ptr + 4*i);
         models0.axi_mem[(ptr >> 2) + i] = exp_tx[i];
      end
   endtask

   task automatic fill_rx_fb(input int len);
      eth_dma_pkg::word_t w;
      for (int i = 0; i < len; i++) begin
         next_word(w);
         exp_rx[i] = w ^ i;
         models0.rx_fb[i] = exp_rx[i];
      end
   endtask

   // Waits until both interrupt counters reach their targets
   task automatic wait_irqs(input int tx_target, input int rx_target, input string what);
      int n;
      for (n = 0; n < 4000; n++) begin
         @(negedge clk_i);
         if (tx_irq_cnt >= tx_target && rx_irq_cnt >= rx_target)
            return;
      end
      $display("timeout waiting for %s", what);
      err_cnt++;
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_tx_frame(input int len);
      for (int i = 0; i < len; i++)
         check_value($sformatf("tx_fb[%0d]", i), models0.tx_fb[i], exp_tx[i]);
   endtask

   task automatic tx_short_frame();
      fill_ext(32'h100, 3);
      set_bd(0, 3, 1'b0, 32'h100);
      @(posedge clk_i);
      tx_en <= 1'b1;
      wait_irqs(tx_irq_cnt + 1, 0, "tx_irq_o of 3-word frame");
      check_tx_frame(3);
      check_value("bd_word0", models0.bd_mem[0], bd_word0(3, 1'b0) & ~32'h8000);
   endtask

   task automatic tx_long_frame();
      models0.ar_lens.delete();
      fill_ext(32'h400, 10);
      set_bd(1, 10, 1'b0, 32'h400);
      wait_irqs(tx_irq_cnt + 1, 0, "tx_irq_o of 10-word frame");
      check_value("ar_count", models0.ar_lens.size(), 3);
      check_value("arlen0", models0.ar_lens[0], 3);
      check_value("arlen1", models0.ar_lens[1], 3);
      check_value("arlen2", models0.ar_lens[2], 1);
      check_tx_frame(10);
   endtask

   task automatic rx_frame();
      models0.aw_lens.delete();
      fill_rx_fb(7);
      set_bd(4, 7, 1'b0, 32'h800);
      @(posedge clk_i);
      rx_en <= 1'b1;
      wait_irqs(0, rx_irq_cnt + 1, "rx_irq_o of 7-word frame");
      for (int i = 0; i < 7; i++)
         check_value($sformatf("axi_mem[%0d]", i), models0.axi_mem[32'h200 + i], exp_rx[i]);
      check_value("aw_count", models0.aw_lens.size(), 2);
      check_value("awlen0", models0.aw_lens[0], 3);
      check_value("awlen1", models0.aw_lens[1], 2);
      check_value("wlast_err", models0.wlast_err, 0);
      check_value("axi_bready", bready, 1);
      check_value("rx_bd_empty", models0.bd_mem[8][15], 0);
   endtask

   task automatic wrap_and_poll();
      @(posedge clk_i);
      tx_en <= 1'b0;
      repeat (3) @(posedge clk_i);
      fill_ext(32'h1000, 3);
      set_bd(1, 3, 1'b1, 32'h1000);
      fill_ext(32'hc00, 5);
      set_bd(0, 5, 1'b0, 32'hc00);
      tx_en <= 1'b1;
      wait_irqs(tx_irq_cnt + 2, 0, "two tx_irq_o pulses around the wrap");
      // Descriptor 0 is now cleared and only polled
      for (int i = 0; i < 200; i++) begin
         @(negedge clk_i);
         check_value("axi_arvalid", axi_ar.valid, 0);
      end
      fill_ext(32'hc00, 5);
      models0.bd_mem[0] = bd_word0(5, 1'b0);
      wait_irqs(tx_irq_cnt + 1, 0, "tx_irq_o after rearm");
      check_tx_frame(5);
   endtask

   task automatic both_with_stalls();
      int tx0;
      int rx0;
      tx0 = tx_irq_cnt;
      rx0 = rx_irq_cnt;
      @(posedge clk_i);
      stall_on <= 1'b1;
      @(negedge clk_i);
      fill_ext(32'h1400, 9);
      fill_rx_fb(6);
      set_bd(1, 9, 1'b0, 32'h1400);
      set_bd(5, 6, 1'b0, 32'h1800);
      wait_irqs(tx0 + 1, rx0 + 1, "both interrupts with stalls");
      repeat (50) @(negedge clk_i);
      check_value("tx_irq_count", tx_irq_cnt, tx0 + 1);
      check_value("rx_irq_count", rx_irq_cnt, rx0 + 1);
      check_tx_frame(9);
      for (int i = 0; i < 6; i++)
         check_value($sformatf("axi_mem[%0d]", i), models0.axi_mem[32'h600 + i], exp_rx[i]);
      check_value("tx_bd_ready", models0.bd_mem[2][15], 0);
      check_value("rx_bd_empty", models0.bd_mem[10][15], 0);
      check_value("wlast_err", models0.wlast_err, 0);
      stall_on <= 1'b0;
   endtask

   initial begin
      arst_i     = 1'b1;
      tx_en      = 1'b0;
      rx_en      = 1'b0;
      tx_bd_num  = 8'd4;
      stall_on   = 1'b0;
      ready_go   = 4'hf;
      data_lfsr  = 32'hd68f;
      stall_lfsr = 32'hd68f;
      err_cnt    = 0;
      tx_irq_cnt = 0;
      rx_irq_cnt = 0;
      models0.wlast_err = 0;
      for (int i = 0; i < 256; i++)
         models0.bd_mem[i] = '0;
      repeat (3) @(posedge clk_i);
      arst_i <= 1'b0;
      tx_short_frame();
      tx_long_frame();
      rx_frame();
      wrap_and_poll();
      both_with_stalls();
      if (err_cnt == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("Test failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// ==== testbench/eth_dma_tb_models.sv ====
`default_nettype none

module eth_dma_tb_models (
   input  wire                        clk_i,
   input  wire                        arst_i,
   // One enable per ready source: ar, r, w, b
   input  wire [3:0]                  go_i,
   input  wire eth_dma_pkg::bd_cmd_t  bd_cmd_i,
   output eth_dma_pkg::word_t         bd_rdata_o,
   input  wire eth_dma_pkg::fb_wr_t   tx_fb_wr_i,
   input  wire eth_dma_pkg::fb_rd_t   rx_fb_rd_i,
   output eth_dma_pkg::word_t         rx_fb_rdata_o,
   input  wire eth_dma_pkg::axi_ar_t  axi_ar_i,
   output logic                       axi_arready_o,
   output eth_dma_pkg::word_t         axi_rdata_o,
   output logic                       axi_rvalid_o,
   output logic                       axi_rlast_o,
   input  wire                        axi_rready_i,
   input  wire eth_dma_pkg::axi_aw_t  axi_aw_i,
   output logic                       axi_awready_o,
   input  wire eth_dma_pkg::axi_w_t   axi_w_i,
   output logic                       axi_wready_o,
   output logic                       axi_bvalid_o
);

   eth_dma_pkg::word_t     bd_mem [0:255];
   eth_dma_pkg::word_t     tx_fb [0:511];
   eth_dma_pkg::word_t     rx_fb [0:511];
   // Word addressed, byte address bits 13..2
   eth_dma_pkg::word_t     axi_mem [0:4095];
   eth_dma_pkg::axi_len_t  ar_lens [$];
   eth_dma_pkg::axi_len_t  aw_lens [$];
   int                     wlast_err;

   logic                   rd_active;
   logic [11:0]            rd_base;
   eth_dma_pkg::axi_len_t  rd_cnt;
   eth_dma_pkg::axi_len_t  rd_len;
   logic                   wr_active;
   logic [11:0]            wr_base;
   eth_dma_pkg::axi_len_t  wr_cnt;
   eth_dma_pkg::axi_len_t  wr_len;
   logic                   b_pend;

   always @(posedge clk_i) begin
      if (bd_cmd_i.en) begin
         if (bd_cmd_i.we)
            bd_mem[bd_cmd_i.addr] <= bd_cmd_i.wdata;
         else
            bd_rdata_o <= bd_mem[bd_cmd_i.addr];
      end
      if (tx_fb_wr_i.we)
         tx_fb[tx_fb_wr_i.addr] <= tx_fb_wr_i.data;
      if (rx_fb_rd_i.en)
         rx_fb_rdata_o <= rx_fb[rx_fb_rd_i.addr];
   end

   assign axi_rdata_o = axi_mem[rd_base + 12'(rd_cnt)];
   assign axi_rlast_o = (rd_cnt == rd_len);

   // Read slave, one burst at a time
   always @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rd_active     <= 1'b0;
         axi_arready_o <= 1'b0;
         axi_rvalid_o  <= 1'b0;
         rd_cnt        <= '0;
         rd_len        <= '0;
      end else if (!rd_active) begin
         axi_arready_o <= go_i[0];
         if (axi_ar_i.valid && axi_arready_o) begin
            ar_lens.push_back(axi_ar_i.len);
            rd_active     <= 1'b1;
            rd_base       <= axi_ar_i.addr[13:2];
            rd_cnt        <= '0;
            rd_len        <= axi_ar_i.len;
            axi_arready_o <= 1'b0;
         end
      end else if (axi_rvalid_o && axi_rready_i) begin
         if (axi_rlast_o) begin
            rd_active    <= 1'b0;
            axi_rvalid_o <= 1'b0;
         end else begin
            rd_cnt       <= rd_cnt + 1'b1;
            axi_rvalid_o <= go_i[1];
         end
      end else if (!axi_rvalid_o) begin
         axi_rvalid_o <= go_i[1];
      end
   end

   // Write slave with a single pending response
   always @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_active     <= 1'b0;
         axi_awready_o <= 1'b0;
         axi_wready_o  <= 1'b0;
         axi_bvalid_o  <= 1'b0;
         b_pend        <= 1'b0;
         wr_cnt        <= '0;
         wr_len        <= '0;
      end else begin
         if (axi_bvalid_o)
            axi_bvalid_o <= 1'b0;
         else if (b_pend && go_i[3]) begin
            axi_bvalid_o <= 1'b1;
            b_pend       <= 1'b0;
         end
         if (!wr_active) begin
            axi_awready_o <= go_i[0] && !b_pend && !axi_bvalid_o;
            if (axi_aw_i.valid && axi_awready_o) begin
               aw_lens.push_back(axi_aw_i.len);
               wr_active     <= 1'b1;
               wr_base       <= axi_aw_i.addr[13:2];
               wr_cnt        <= '0;
               wr_len        <= axi_aw_i.len;
               axi_awready_o <= 1'b0;
               axi_wready_o  <= go_i[2];
            end
         end else begin
            axi_wready_o <= go_i[2];
            if (axi_w_i.valid && axi_wready_o) begin
               axi_mem[wr_base + 12'(wr_cnt)] <= axi_w_i.data;
               if (axi_w_i.last != (wr_cnt == wr_len))
                  wlast_err <= wlast_err + 1;
               wr_cnt <= wr_cnt + 1'b1;
               if (wr_cnt == wr_len) begin
                  wr_active    <= 1'b0;
                  axi_wready_o <= 1'b0;
                  b_pend       <= 1'b1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire
